// ==== vlog.f ====
bias_pkg.sv
bias_load_if.sv
bias_loader.sv
bias_regs.sv
bias_add.sv
bias_top.sv
tb_bias_top.sv

// ==== tb_bias_top.sv ====
`timescale 1ns/1ps

module tb_bias_top;

  localparam int unsigned seed       = 32'h2174_3791;
  localparam int unsigned wait_limit = 64;
  localparam int unsigned lanes      = bias_pkg::sa_row_num;
  localparam int unsigned set_w      = bias_pkg::bias_set_width;
  localparam int unsigned acc_w      = bias_pkg::acc_width;

  logic                                  clk;
  logic                                  reset;
  logic                                  word_strobe;
  logic [bias_pkg::mode_width-1:0]       word_mode;
  logic [bias_pkg::bias_word_length-1:0] bias_word;
  logic [bias_pkg::row_idx_width-1:0]    out_row_idx;
  logic [lanes*acc_w-1:0]                acc_in;
  logic [lanes*acc_w-1:0]                result;

  // reference table with entry k holding set k+1
  logic signed [set_w-1:0] model_tbl [bias_pkg::bias_entries];
  logic                    model_upper;
  // per-edge history with the newest at the back
  logic [lanes*set_w-1:0]  bias_q [$];
  logic [lanes*acc_w-1:0]  acc_q [$];
  logic [acc_w-1:0]        exp_res [lanes];
  logic                    chk_en = 1'b0;
  int                      checks_done;
  string                   test_name;

  bias_top bias_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // signed add clamped to 32 bits
  function automatic logic [acc_w-1:0] sat_add(logic signed [set_w-1:0] b,
                                               logic signed [acc_w-1:0] a);
    longint max_pos;
    longint s;
    max_pos = 2147483647;
    s = longint'(a) + longint'(b);
    if (s > max_pos) return 32'h7fff_ffff;
    if (s < -max_pos - 1) return 32'h8000_0000;
    return s[acc_w-1:0];
  endfunction

  // idx 0 means no bias on any array row
  function automatic logic [set_w-1:0] bias_for(int idx, int lane);
    if (idx == 0) return '0;
    return model_tbl[lane * bias_pkg::row_num_in_sa + idx - 1];
  endfunction

  // lane l+1 takes the bias of the index from l+2 edges back and acc_in of this edge
  always @(posedge clk) begin : record
    logic [lanes*set_w-1:0] sets;
    if (reset) begin
      bias_q.delete();
      acc_q.delete();
      chk_en <= 1'b0;
      checks_done <= 0;
    end else begin
      if (chk_en) checks_done <= checks_done + 1;
      for (int l = 0; l < lanes; l++) sets[l*set_w +: set_w] = bias_for(out_row_idx, l);
      bias_q.push_back(sets);
      acc_q.push_back(acc_in);
      if (bias_q.size() > 6) begin
        void'(bias_q.pop_front());
        void'(acc_q.pop_front());
      end
      if (bias_q.size() == 6) begin
        for (int l = 0; l < lanes; l++) begin
          exp_res[l] <= sat_add(bias_q[3-l][l*set_w +: set_w], acc_q[5][l*acc_w +: acc_w]);
        end
        chk_en <= 1'b1;
      end
    end
  end

  for (genvar l = 0; l < lanes; l++) begin : g_check
    assert property (@(posedge clk) !chk_en || (result[l*acc_w +: acc_w] == exp_res[l]))
      else begin
        $display("MISMATCH %s lane %0d expected %h actual %h", test_name, l + 1,
                 $sampled(exp_res[l]), $sampled(result[l*acc_w +: acc_w]));
        abort_run();
      end
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [lanes*acc_w-1:0] rand_acc();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // lanes just below max or just above min
  function automatic logic [lanes*acc_w-1:0] edge_acc(bit top);
    logic [lanes*acc_w-1:0] a;
    for (int l = 0; l < lanes; l++) begin
      a[l*acc_w +: acc_w] = (top ? 32'h7fff_0000 : 32'h8000_0000) + ($urandom & 32'hffff);
    end
    return a;
  endfunction

  function automatic logic [bias_pkg::bias_word_length-1:0] rand_word();
    logic [bias_pkg::bias_word_length-1:0] w;
    for (int i = 0; i < bias_pkg::bias_word_length / 32; i++) w[i*32 +: 32] = $urandom;
    return w;
  endfunction

  task automatic step(input int idx, input logic [lanes*acc_w-1:0] acc);
    @(negedge clk);
    out_row_idx = idx;
    acc_in = acc;
  endtask

  task automatic traffic(input int n);
    repeat (n) step($urandom % 17, rand_acc());
  endtask

  // index 0 first and then every output row
  task automatic sweep();
    for (int i = 0; i <= bias_pkg::row_num_in_sa; i++) step(i, rand_acc());
  endtask

  // strobe one word and update the model once the write has landed
  task automatic load_word(input logic [bias_pkg::mode_width-1:0] mode,
                           input logic [bias_pkg::bias_word_length-1:0] word);
    int  lo;
    bit  ok;
    traffic(1);
    word_strobe = 1'b1;
    word_mode = mode;
    bias_word = word;
    ok = 1'b1;
    lo = 0;
    if (mode == bias_pkg::mode_bytes) model_upper = 1'b0;
    else if (mode == bias_pkg::mode_sets) begin
      lo = model_upper ? 32 : 0;
      model_upper = !model_upper;
    end else ok = 1'b0;
    traffic(1);
    word_strobe = 1'b0;
    traffic(1);
    // table written on the edge just passed
    for (int k = lo; ok && k < ((mode == bias_pkg::mode_sets) ? lo + 32 : 64); k++) begin
      model_tbl[k] = (mode == bias_pkg::mode_bytes) ? {8'h00, word[k*8 +: 8]}
                                                    : word[(k-lo)*set_w +: set_w];
    end
  endtask

  task automatic wait_checker_live();
    int n;
    n = 0;
    while (!chk_en && n < wait_limit) begin
      traffic(1);
      n++;
    end
    if (!chk_en) begin
      $display("timeout waiting for the result checker to arm after reset");
      abort_run();
    end
  endtask

  task automatic wait_drain();
    int n;
    int target;
    n = 0;
    target = checks_done + 8;
    while (checks_done < target && n < wait_limit) begin
      step(0, rand_acc());
      n++;
    end
    if (checks_done < target) begin
      $display("timeout waiting for the last results to be checked");
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(seed));
    reset = 1'b1;
    word_strobe = 1'b0;
    word_mode = '0;
    bias_word = '0;
    out_row_idx = '0;
    acc_in = '0;
    model_upper = 1'b0;
    for (int k = 0; k < bias_pkg::bias_entries; k++) model_tbl[k] = '0;
    test_name = "reset_state";
    repeat (16) @(negedge clk);
    reset = 1'b0;
    wait_checker_live();
    traffic(24);
    test_name = "mode0_load";
    load_word(0, rand_word());
    traffic(2);
    sweep();
    sweep();
    // lower and upper, lower again, then mode 0 while the upper half is next
    test_name = "mode1_halves";
    load_word(1, rand_word());
    load_word(1, rand_word());
    traffic(2);
    sweep();
    load_word(1, rand_word());
    traffic(2);
    sweep();
    load_word(0, rand_word());
    load_word(1, rand_word());
    traffic(2);
    sweep();
    test_name = "masked_write";
    load_word(2, rand_word());
    load_word(7, rand_word());
    load_word(4'hf, rand_word());
    traffic(2);
    sweep();
    load_word(0, rand_word());
    load_word(1, rand_word());
    traffic(2);
    sweep();
    test_name = "index_zero";
    repeat (20) step(0, rand_acc());
    for (int i = 0; i < 20; i++) step((i % 2) ? 0 : 1 + $urandom % 16, rand_acc());
    // whole table at one extreme with acc_in pushed the same way
    test_name = "saturation";
    load_word(1, {32{16'h7fff}});
    load_word(1, {32{16'h7fff}});
    traffic(2);
    repeat (24) step(1 + $urandom % 16, edge_acc(1'b1));
    load_word(1, {32{16'h8000}});
    load_word(1, {32{16'h8000}});
    traffic(2);
    repeat (24) step(1 + $urandom % 16, edge_acc(1'b0));
    wait_drain();
    if (checks_done >= 200) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("only %0d result cycles were checked", checks_done);
      abort_run();
    end
  end

endmodule

// ==== bias_top.sv ====
`timescale 1ns/1ps

module bias_top (
  input  logic                                                clk,
  input  logic                                                reset,
  input  logic                                                word_strobe,
  input  logic [bias_pkg::mode_width-1:0]                     word_mode,
  input  logic [bias_pkg::bias_word_length-1:0]               bias_word,
  input  logic [bias_pkg::row_idx_width-1:0]                  out_row_idx,
  input  logic [bias_pkg::sa_row_num*bias_pkg::acc_width-1:0] acc_in,
  output logic [bias_pkg::sa_row_num*bias_pkg::acc_width-1:0] result
);

  // skewed bias sets, four lanes
  logic [bias_pkg::sa_row_num*bias_pkg::bias_set_width-1:0] bias_sets;

  //////////////////////////////////////////////////
  // write path
  //////////////////////////////////////////////////

  bias_load_if load_if_i ();

  bias_loader loader_i (
    .clk         (clk),
    .reset       (reset),
    .word_strobe (word_strobe),
    .word_mode   (word_mode),
    .bias_word   (bias_word),
    .load        (load_if_i.source)
  );

  //////////////////////////////////////////////////
  // table and bias adder
  //////////////////////////////////////////////////

  bias_regs regs_i (
    .clk         (clk),
    .reset       (reset),
    .load        (load_if_i.sink),
    .out_row_idx (out_row_idx),
    .bias_sets   (bias_sets)
  );

  bias_add add_i (
    .clk       (clk),
    .reset     (reset),
    .bias_sets (bias_sets),
    .acc_in    (acc_in),
    .result    (result)
  );

endmodule

// ==== bias_add.sv ====
`timescale 1ns/1ps

module bias_add (
  input  logic                                                     clk,
  input  logic                                                     reset,
  input  logic [bias_pkg::sa_row_num*bias_pkg::bias_set_width-1:0] bias_sets,
  input  logic [bias_pkg::sa_row_num*bias_pkg::acc_width-1:0]      acc_in,
  output logic [bias_pkg::sa_row_num*bias_pkg::acc_width-1:0]      result
);

  // one guard bit over the lane width
  logic [bias_pkg::acc_width:0]        bias_ext [bias_pkg::sa_row_num];
  logic [bias_pkg::acc_width:0]        acc_ext  [bias_pkg::sa_row_num];
  logic [bias_pkg::acc_width:0]        sum      [bias_pkg::sa_row_num];
  logic [bias_pkg::acc_width-1:0]      sat      [bias_pkg::sa_row_num];
  logic [bias_pkg::acc_width-1:0]      res_q    [bias_pkg::sa_row_num];
  logic [bias_pkg::bias_set_width-1:0] bias_lane [bias_pkg::sa_row_num];

  //////////////////////////////////////////////////
  // widen and add
  //////////////////////////////////////////////////

  always_comb begin
    for (int l = 0; l < bias_pkg::sa_row_num; l++) begin
      bias_lane[l] = bias_sets[l*bias_pkg::bias_set_width +: bias_pkg::bias_set_width];
      // bias set is signed, sign bit copied up
      bias_ext[l] = {{(bias_pkg::acc_width + 1 - bias_pkg::bias_set_width)
                       {bias_lane[l][bias_pkg::bias_set_width-1]}},
                     bias_lane[l]};
      acc_ext[l]  = {acc_in[(l + 1)*bias_pkg::acc_width - 1],
                     acc_in[l*bias_pkg::acc_width +: bias_pkg::acc_width]};
      sum[l]      = bias_ext[l] + acc_ext[l];
    end
  end

  //////////////////////////////////////////////////
  // saturate to signed 32 bits
  //////////////////////////////////////////////////

  always_comb begin
    for (int l = 0; l < bias_pkg::sa_row_num; l++) begin
      if (sum[l][bias_pkg::acc_width] != sum[l][bias_pkg::acc_width-1]) begin
        // guard bit gives the true sign of the overflow
        if (sum[l][bias_pkg::acc_width]) begin
          sat[l] = {1'b1, {(bias_pkg::acc_width - 1){1'b0}}};
        end else begin
          sat[l] = {1'b0, {(bias_pkg::acc_width - 1){1'b1}}};
        end
      end else begin
        sat[l] = sum[l][bias_pkg::acc_width-1:0];
      end
    end
  end

  //////////////////////////////////////////////////
  // result register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int l = 0; l < bias_pkg::sa_row_num; l++) begin
        res_q[l] <= '0;
      end
    end else begin
      for (int l = 0; l < bias_pkg::sa_row_num; l++) begin
        res_q[l] <= sat[l];
      end
    end
  end

  // lanes packed back, lane 1 low
  for (genvar l = 0; l < bias_pkg::sa_row_num; l++) begin : g_out
    assign result[l*bias_pkg::acc_width +: bias_pkg::acc_width] = res_q[l];
  end

endmodule

// ==== bias_regs.sv ====
`timescale 1ns/1ps

module bias_regs (
  input  logic                                                  clk,
  input  logic                                                  reset,
  bias_load_if.sink                                             load,
  input  logic [bias_pkg::row_idx_width-1:0]                    out_row_idx,
  output logic [bias_pkg::sa_row_num*bias_pkg::bias_set_width-1:0] bias_sets
);

  // bias set table, entry k holds set number k+1
  logic [bias_pkg::bias_set_width-1:0] table_q [bias_pkg::bias_entries];

  // decoded write data and entry enables
  logic [bias_pkg::bias_set_width-1:0] wr_sets [bias_pkg::bias_entries];
  logic [bias_pkg::bias_entries-1:0]   wr_mask;

  // read side
  logic                                idx_ok;
  logic [bias_pkg::row_idx_width-1:0]  idx_m1;
  logic [bias_pkg::bias_set_width-1:0] row_rd [bias_pkg::sa_row_num];

  //////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < bias_pkg::bias_entries; k++) begin
      // inclusive range, entries counted from 1
      wr_mask[k] = load.wr
                   && (k + 1 >= int'(load.first))
                   && (k + 1 <= int'(load.last));
      if (load.mode == bias_pkg::mode_bytes) begin
        // byte k zero-extended into slot k
        wr_sets[k] = {{(bias_pkg::bias_set_width - bias_pkg::bias_width){1'b0}},
                      load.word[k*bias_pkg::bias_width +: bias_pkg::bias_width]};
      end else begin
        // 32 sets repeat over both halves, the mask picks one
        wr_sets[k] = load.word[(k % (bias_pkg::bias_entries / 2))
                               * bias_pkg::bias_set_width +: bias_pkg::bias_set_width];
      end
    end
  end

  //////////////////////////////////////////////////
  // table
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < bias_pkg::bias_entries; k++) begin
        table_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < bias_pkg::bias_entries; k++) begin
        if (wr_mask[k]) begin
          table_q[k] <= wr_sets[k];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // read, one entry per array row
  //////////////////////////////////////////////////

  // idx 0 and anything past the array height read as zero bias
  assign idx_ok = (out_row_idx != '0)
                  && (int'(out_row_idx) <= bias_pkg::row_num_in_sa);
  assign idx_m1 = out_row_idx - 1'b1;

  always_comb begin
    for (int r = 0; r < bias_pkg::sa_row_num; r++) begin
      if (idx_ok) begin
        row_rd[r] = table_q[bias_pkg::row_idx_width'(r * bias_pkg::row_num_in_sa) + idx_m1];
      end else begin
        row_rd[r] = '0;
      end
    end
  end

  // row r+1 runs r+2 stages deep, the last stage drives lane r+1
  for (genvar r = 0; r < bias_pkg::sa_row_num; r++) begin : g_skew
    logic [bias_pkg::bias_set_width-1:0] dly_q [r+2];

    always_ff @(posedge clk) begin
      if (reset) begin
        for (int s = 0; s < r + 2; s++) begin
          dly_q[s] <= '0;
        end
      end else begin
        dly_q[0] <= row_rd[r];
        for (int s = 1; s < r + 2; s++) begin
          dly_q[s] <= dly_q[s-1];
        end
      end
    end

    // array row 1 sits in the low lane
    assign bias_sets[r*bias_pkg::bias_set_width +: bias_pkg::bias_set_width] = dly_q[r+1];
  end

endmodule

// ==== bias_loader.sv ====
`timescale 1ns/1ps

module bias_loader (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  word_strobe,
  input  logic [bias_pkg::mode_width-1:0]       word_mode,
  input  logic [bias_pkg::bias_word_length-1:0] bias_word,
  bias_load_if.source                           load
);

  // same width as the range fields of the interface
  localparam int unsigned ent_w = $clog2(bias_pkg::bias_entries + 1);

  logic is_bytes;
  logic is_sets;
  // 0 = lower half next, 1 = upper half next
  logic half_q;

  //////////////////////////////////////////////////
  // mode decode
  //////////////////////////////////////////////////

  assign is_bytes = (word_mode == bias_pkg::mode_bytes);
  assign is_sets  = (word_mode == bias_pkg::mode_sets);

  //////////////////////////////////////////////////
  // strobe and half select
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      load.wr <= 1'b0;
      half_q  <= 1'b0;
    end else begin
      // unknown modes are dropped here
      load.wr <= word_strobe && (is_bytes || is_sets);
      if (word_strobe && is_bytes) begin
        // full table load, next set word starts low again
        half_q <= 1'b0;
      end else if (word_strobe && is_sets) begin
        // lower then upper, then wraps
        half_q <= ~half_q;
      end
    end
  end

  //////////////////////////////////////////////////
  // command payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (word_strobe && is_bytes) begin
      load.mode  <= bias_pkg::mode_bytes;
      load.word  <= bias_word;
      load.first <= ent_w'(1);
      load.last  <= ent_w'(bias_pkg::bias_entries);
    end else if (word_strobe && is_sets) begin
      load.mode <= bias_pkg::mode_sets;
      load.word <= bias_word;
      // 32 sets per word, half of the table
      if (half_q) begin
        load.first <= ent_w'(bias_pkg::bias_entries / 2 + 1);
        load.last  <= ent_w'(bias_pkg::bias_entries);
      end else begin
        load.first <= ent_w'(1);
        load.last  <= ent_w'(bias_pkg::bias_entries / 2);
      end
    end
  end

endmodule

// ==== bias_load_if.sv ====
`timescale 1ns/1ps

// one table write command, loader to register file
interface bias_load_if;

  // entry numbers run 1..64, so one extra bit over the address
  localparam int unsigned ent_w = $clog2(bias_pkg::bias_entries + 1);

  // single cycle strobe, no handshake
  logic                                  wr;
  bias_pkg::bias_mode_t                  mode;
  logic [bias_pkg::bias_word_length-1:0] word;
  // inclusive entry range [first, last]
  logic [ent_w-1:0]                      first;
  logic [ent_w-1:0]                      last;

  // loader side
  modport source (output wr, mode, word, first, last);

  // register file side
  modport sink (input wr, mode, word, first, last);

endinterface

// ==== bias_pkg.sv ====
package bias_pkg;

  //////////////////////////////////////////////////
  // conv core geometry
  //////////////////////////////////////////////////

  // array rows stacked in the core
  localparam int unsigned sa_row_num = 4;

  // output rows inside one array
  localparam int unsigned row_num_in_sa = 16;

  // one bias set per array row per output row
  localparam int unsigned bias_entries = 64;

  //////////////////////////////////////////////////
  // data widths
  //////////////////////////////////////////////////

  // raw byte bias, mode 0 packing
  localparam int unsigned bias_width = 8;

  // table entry width
  localparam int unsigned bias_set_width = 16;

  // incoming bias bus
  localparam int unsigned bias_word_length = 512;

  // accumulator and result lanes
  localparam int unsigned acc_width = 32;

  // output row index, 0 means no bias
  localparam int unsigned row_idx_width = 6;

  // mode field on the bias bus
  localparam int unsigned mode_width = 4;

  // packing of the 512-bit word
  typedef enum logic [mode_width-1:0] {
    mode_bytes = mode_width'(0),
    mode_sets  = mode_width'(1)
  } bias_mode_t;

endpackage
